//--- dv/ps2_display_tb.sv
`default_nettype none

module ps2_display_tb;

    localparam int MAX_TESTS   = 16;
    localparam int HALF_PERIOD = 40;    // System cycles per ps2_clk half period
    localparam int WAIT_WINDOW = 100;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] seg1;
    logic [7:0] seg2;

    // One row of stimulus and expected display per test
    string      tbl_name  [MAX_TESTS];
    logic [7:0] tbl_bytes [MAX_TESTS][3];
    int         tbl_len   [MAX_TESTS];
    bit         tbl_bad   [MAX_TESTS];
    bit         tbl_blank [MAX_TESTS];
    logic [7:0] tbl_code  [MAX_TESTS];
    int         num_tests;

    ps2_display DUT
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reference segment table in dp g f e d c b a order with active-low bits
    function automatic logic [7:0] seg_ref(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    function automatic void add_entry(input string name, input int len,
                                      input logic [7:0] b0, input logic [7:0] b1,
                                      input logic [7:0] b2, input bit bad,
                                      input bit blk, input logic [7:0] code);
        tbl_name[num_tests]     = name;
        tbl_len[num_tests]      = len;
        tbl_bytes[num_tests][0] = b0;
        tbl_bytes[num_tests][1] = b1;
        tbl_bytes[num_tests][2] = b2;
        tbl_bad[num_tests]      = bad;
        tbl_blank[num_tests]    = blk;
        tbl_code[num_tests]     = code;
        num_tests++;
    endfunction

    // Any byte except 00 and the two prefixes
    function automatic logic [7:0] random_make();
        logic [31:0] r;
        logic [7:0]  c;
        c = 8'h00;
        while (c == 8'h00 || c == 8'hE0 || c == 8'hF0)
        begin
            r = $urandom();
            c = r[7:0];
        end
        return c;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] b, input bit bad_parity);
        logic [10:0] frm;
        logic        par;
        par = bad_parity ? ^b : ~^b;
        frm = {1'b1, par, b, 1'b0};
        for (int k = 0; k < 11; k++)
        begin
            @(posedge clk);
            ps2_dat <= frm[k];
            wait_cycles(HALF_PERIOD / 2);
            ps2_clk <= 1'b0;                // Keyboard data is valid on the fall
            wait_cycles(HALF_PERIOD);
            ps2_clk <= 1'b1;
            wait_cycles(HALF_PERIOD / 2);
        end
        ps2_dat <= 1'b1;
    endtask

    task automatic wait_display(input logic [7:0] e1, input logic [7:0] e2, output bit hit);
        int cnt;
        hit = 1'b0;
        cnt = 0;
        while (!hit && cnt < WAIT_WINDOW)
        begin
            @(posedge clk);
            if (seg1 == e1 && seg2 == e2)
                hit = 1'b1;
            cnt++;
        end
    endtask

    initial
    begin
        logic [7:0]  r1;
        logic [7:0]  r2;
        logic [7:0]  r3;
        logic [7:0]  r4;
        logic [7:0]  exp1;
        logic [7:0]  exp2;
        bit          hit;
        bit          test_ok;
        int          passed;
        int          failed;

        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        passed  = 0;
        failed  = 0;

        void'($urandom(32'hd900_f7b2));
        r1 = random_make();
        r2 = random_make();
        r3 = random_make();
        r4 = random_make();

        num_tests = 0;
        add_entry("reset",        0, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 8'h00);
        add_entry("make_1c",      1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b0, 8'h1C);
        add_entry("make_5a",      1, 8'h5A, 8'h00, 8'h00, 1'b0, 1'b0, 8'h5A);
        add_entry("make_rand1",   1, r1,    8'h00, 8'h00, 1'b0, 1'b0, r1);
        add_entry("make_rand2",   1, r2,    8'h00, 8'h00, 1'b0, 1'b0, r2);
        add_entry("break_5a",     2, 8'hF0, 8'h5A, 8'h00, 1'b0, 1'b1, 8'h00);
        add_entry("make_33",      1, 8'h33, 8'h00, 8'h00, 1'b0, 1'b0, 8'h33);
        add_entry("ext_alone",    1, 8'hE0, 8'h00, 8'h00, 1'b0, 1'b0, 8'h33);   // Prefix shows nothing
        add_entry("ext_rand3",    2, 8'hE0, r3,    8'h00, 1'b0, 1'b0, r3);
        add_entry("ext_75",       2, 8'hE0, 8'h75, 8'h00, 1'b0, 1'b0, 8'h75);
        add_entry("bad_parity",   1, 8'h29, 8'h00, 8'h00, 1'b1, 1'b0, 8'h75);   // Display holds
        add_entry("good_after",   1, 8'h29, 8'h00, 8'h00, 1'b0, 1'b0, 8'h29);
        add_entry("make_rand4",   1, r4,    8'h00, 8'h00, 1'b0, 1'b0, r4);

        repeat (16) @(posedge clk);
        rst <= 1'b1;

        for (int i = 0; i < num_tests; i++)
        begin
            test_ok = 1'b1;
            for (int j = 0; j < tbl_len[i]; j++)
                send_frame(tbl_bytes[i][j], tbl_bad[i] && j == tbl_len[i] - 1);

            exp1 = tbl_blank[i] ? 8'hFF : seg_ref(tbl_code[i][3:0]);
            exp2 = tbl_blank[i] ? 8'hFF : seg_ref(tbl_code[i][7:4]);

            if (tbl_bad[i])
                wait_cycles(WAIT_WINDOW);   // Nothing may change in the window
            else
            begin
                wait_display(exp1, exp2, hit);
                if (!hit)
                begin
                    $display("Test %s timed out: display never reached the expected value",
                             tbl_name[i]);
                    test_ok = 1'b0;
                end
            end

            assert (seg1 == exp1)
            else
            begin
                $display("ERROR %s: seg1 expected %h, got %h", tbl_name[i], exp1, seg1);
                test_ok = 1'b0;
            end
            assert (seg2 == exp2)
            else
            begin
                $display("ERROR %s: seg2 expected %h, got %h", tbl_name[i], exp2, seg2);
                test_ok = 1'b0;
            end

            if (test_ok)
                passed++;
            else
                failed++;
            $display("%-12s %s", tbl_name[i], test_ok ? "ok" : "failed");
        end

        $display("%0d tests, %0d passed, %0d failed", num_tests, passed, failed);
        if (failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- include/ps2_macros.svh
`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// Input synchronizer depth for ps2_clk and ps2_dat
`define PS2_SYNC_STAGES 3

// Receive FIFO geometry, depth must equal 2**AW
`define PS2_FIFO_DEPTH  4
`define PS2_FIFO_AW     2

// Scan code prefixes
`define PS2_BREAK_CODE  8'hF0
`define PS2_EXT_CODE    8'hE0

// Active-low segments, all dark including dp
`define SEG_BLANK       8'hFF

`endif

//--- logic/key_tracker.sv
`default_nettype none

`include "ps2_macros.svh"

module key_tracker
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ready,
    input  ps2_pkg::key_code_t data,
    output logic               nextdata_n,
    output ps2_pkg::key_code_t key_value,
    output logic               blank
);

    import ps2_pkg::*;

    trk_state_t state;
    key_code_t  code_q;
    logic       brk_flag;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state      <= TRK_IDLE;
            nextdata_n <= 1'b1;
        end
        else
        begin
            nextdata_n <= 1'b1;
            case (state)
                TRK_IDLE:
                    if (ready)
                    begin
                        state      <= TRK_POP;
                        nextdata_n <= 1'b0;     // Head consumed at end of TRK_POP
                    end
                TRK_POP:
                    if (data == `PS2_BREAK_CODE)
                        state <= TRK_BREAK;
                    else if (data == `PS2_EXT_CODE)
                        state <= TRK_EXT;
                    else
                        state <= TRK_MAKE;
                default: state <= TRK_IDLE;
            endcase
        end
    end

    // Keep the byte, the FIFO head moves on after the pop
    always_ff @(posedge clk)
    begin
        if (state == TRK_POP)
            code_q <= data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            brk_flag  <= 1'b0;
            blank     <= 1'b1;
            key_value <= '0;
        end
        else
        begin
            case (state)
                TRK_BREAK: brk_flag <= 1'b1;
                TRK_MAKE:
                    if (brk_flag)
                    begin
                        // Key released
                        blank    <= 1'b1;
                        brk_flag <= 1'b0;
                    end
                    else
                    begin
                        key_value <= code_q;
                        blank     <= 1'b0;
                    end
                default: ;  // E0 leaves everything as is
            endcase
        end
    end

    a_pop_when_ready: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> ready)
        else $error("key_tracker: pop while receiver FIFO empty");

    a_pop_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |=> nextdata_n)
        else $error("key_tracker: nextdata_n low for two cycles");

endmodule

`default_nettype wire

//--- logic/ps2_display.sv
`default_nettype none

module ps2_display
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg1,
    output logic [7:0] seg2
);

    import ps2_pkg::*;

    logic      ready;
    logic      nextdata_n;
    key_code_t data;
    key_code_t key_value;
    logic      blank;

    ps2_receiver u_receiver
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (data),
        .ready      (ready)
    );

    key_tracker u_tracker
    (
        .clk        (clk),
        .rst        (rst),
        .ready      (ready),
        .data       (data),
        .nextdata_n (nextdata_n),
        .key_value  (key_value),
        .blank      (blank)
    );

    // Low nibble on seg1, high nibble on seg2
    seg7_decoder u_seg_lo (.num(key_value[3:0]), .blank(blank), .seg_out(seg1));
    seg7_decoder u_seg_hi (.num(key_value[7:4]), .blank(blank), .seg_out(seg2));

endmodule

`default_nettype wire

//--- logic/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // One byte as delivered by the keyboard
    typedef logic [7:0] key_code_t;

    // Receiver framing
    typedef enum logic [1:0]
    {
        RX_IDLE  = 2'd0,    // Waiting for the start bit edge
        RX_SHIFT = 2'd1,
        RX_CHECK = 2'd2     // One cycle, frame complete
    } rx_state_t;

    // Key tracker
    typedef enum logic [2:0]
    {
        TRK_IDLE  = 3'd0,
        TRK_POP   = 3'd1,   // nextdata_n low here
        TRK_MAKE  = 3'd2,
        TRK_BREAK = 3'd3,
        TRK_EXT   = 3'd4
    } trk_state_t;

endpackage

`default_nettype wire

//--- logic/ps2_receiver.sv
`default_nettype none

`include "ps2_macros.svh"

module ps2_receiver
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ps2_clk,
    input  logic               ps2_dat,
    input  logic               nextdata_n,
    output ps2_pkg::key_code_t data,
    output logic               ready
);

    import ps2_pkg::*;

    logic [`PS2_SYNC_STAGES-1:0] clk_sync;
    logic [`PS2_SYNC_STAGES-1:0] dat_sync;
    logic                        clk_prev;
    logic                        clk_fall;
    logic                        bit_in;

    rx_state_t   rx_state;
    logic [3:0]  bit_cnt;
    logic [10:0] frame;
    logic        frame_ok;

    key_code_t             mem [`PS2_FIFO_DEPTH];
    logic [`PS2_FIFO_AW:0] wptr;
    logic [`PS2_FIFO_AW:0] rptr;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  pop;

    // Lines idle high, so reset to 1 to avoid a false edge
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[`PS2_SYNC_STAGES-2:0], ps2_dat};
            clk_prev <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[`PS2_SYNC_STAGES-1];
    assign bit_in   = dat_sync[`PS2_SYNC_STAGES-1];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rx_state <= RX_IDLE;
            bit_cnt  <= '0;
        end
        else
        begin
            case (rx_state)
                RX_IDLE:
                    if (clk_fall)
                    begin
                        rx_state <= RX_SHIFT;
                        bit_cnt  <= 4'd1;   // Start bit taken
                    end
                RX_SHIFT:
                    if (clk_fall)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd10)
                            rx_state <= RX_CHECK;
                    end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in at the top
    always_ff @(posedge clk)
    begin
        if (clk_fall && rx_state != RX_CHECK)
            frame <= {bit_in, frame[10:1]};
    end

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    assign push  = (rx_state == RX_CHECK) && frame_ok && !full;
    assign pop   = !nextdata_n && !empty;
    assign empty = (wptr == rptr);
    assign full  = (wptr[`PS2_FIFO_AW] != rptr[`PS2_FIFO_AW]) &&
                   (wptr[`PS2_FIFO_AW-1:0] == rptr[`PS2_FIFO_AW-1:0]);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            if (push)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wptr[`PS2_FIFO_AW-1:0]] <= frame[8:1];
    end

    assign ready = !empty;
    assign data  = mem[rptr[`PS2_FIFO_AW-1:0]];

    // Tracker has to drain the FIFO faster than frames arrive
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        (rx_state == RX_CHECK && frame_ok) |-> !full)
        else $error("ps2_receiver: good frame arrived with FIFO full");

endmodule

`default_nettype wire

//--- logic/seg7_decoder.sv
`default_nettype none

`include "ps2_macros.svh"

module seg7_decoder
(
    input  logic [3:0] num,
    input  logic       blank,
    output logic [7:0] seg_out
);

    // Bits are dp g f e d c b a, low lights the segment
    always_comb
    begin
        if (blank)
            seg_out = `SEG_BLANK;
        else
        begin
            case (num)
                4'h0: seg_out = 8'hC0;
                4'h1: seg_out = 8'hF9;
                4'h2: seg_out = 8'hA4;
                4'h3: seg_out = 8'hB0;
                4'h4: seg_out = 8'h99;
                4'h5: seg_out = 8'h92;
                4'h6: seg_out = 8'h82;
                4'h7: seg_out = 8'hF8;
                4'h8: seg_out = 8'h80;
                4'h9: seg_out = 8'h90;
                4'hA: seg_out = 8'h88;
                4'hB: seg_out = 8'h83;
                4'hC: seg_out = 8'hC6;
                4'hD: seg_out = 8'hA1;
                4'hE: seg_out = 8'h86;
                default: seg_out = 8'h8E;   // F
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ps2_display.f
+incdir+include
logic/ps2_pkg.sv
logic/seg7_decoder.sv
logic/ps2_receiver.sv
logic/key_tracker.sv
logic/ps2_display.sv
dv/ps2_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the PS/2 display testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ps2_display_tb -f ps2_display.f &&
./obj_dir/Vps2_display_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
